// ==== sources.f ====
common/issue_pkg.sv
hw/int_alu.sv
hw/ls_unit.sv
hw/mult_pipe.sv
divider/div_step_counter.sv
divider/div_datapath.sv
divider/div_ctrl.sv
hw/cdb_scheduler.sv
hw/issue_top.sv
testbench/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module issue_tb \
   -f sources.f -o issue_sim \
   && ./obj_dir/issue_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== testbench/issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_tb;

   localparam int LS_DEPTH = 16;
   localparam int LS_AW    = $clog2(LS_DEPTH);
   localparam int MAX_ROWS = 64;
   localparam int U_INT    = 0;
   localparam int U_LS     = 1;
   localparam int U_MUL    = 2;
   localparam int U_DIV    = 3;

   typedef struct {
      int                 unit;
      issue_pkg::alu_op_e op;
      logic               write;
      logic [31:0]        a;
      logic [31:0]        b;
      logic [1:0]         rnd;
      int                 gap;
   } row_t;

   logic                clk;
   logic                rst_n;
   issue_pkg::int_req_t int_req;
   logic                int_valid;
   logic                int_ready;
   issue_pkg::ls_req_t  ls_req;
   logic                ls_valid;
   logic                ls_ready;
   issue_pkg::md_req_t  mul_req;
   logic                mul_valid;
   issue_pkg::md_req_t  div_req;
   logic                div_valid;
   logic                div_ready;
   issue_pkg::cdb_t     cdb;

   row_t                rows [MAX_ROWS];
   issue_pkg::cdb_t     exp_res [MAX_ROWS];
   int                  issue_cyc [MAX_ROWS];
   bit                  pending [MAX_ROWS];
   logic [31:0]         ref_mem [LS_DEPTH];

   int     n_rows       = 0;
   int     n_open       = 0;
   int     cyc          = 0;
   int     err_count    = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   int     last_mul     = -10;
   int     prev_mul     = -10;
   int     div_issue    = 0;
   bit     div_busy     = 1'b0;
   bit     prio_exp     = 1'b1;
   bit     checking     = 1'b0;
   bit     table_done   = 1'b0;
   integer seed         = 32'hd6ff;

   issue_top #(
      .LS_DEPTH (LS_DEPTH)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .int_req   (int_req),
      .int_valid (int_valid),
      .int_ready (int_ready),
      .ls_req    (ls_req),
      .ls_valid  (ls_valid),
      .ls_ready  (ls_ready),
      .mul_req   (mul_req),
      .mul_valid (mul_valid),
      .div_req   (div_req),
      .div_valid (div_valid),
      .div_ready (div_ready),
      .cdb       (cdb)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic add_row(input int unit, input issue_pkg::alu_op_e op, input logic write,
                          input logic [31:0] a, input logic [31:0] b, input logic [1:0] rnd,
                          input int gap);
      rows[n_rows] = '{unit, op, write, a, b, rnd, gap};
      n_rows++;
   endtask

   // expected bus word from the unit rules, stores update the shadow memory
   task automatic compute_expected(input int r);
      issue_pkg::cdb_t e;
      logic [31:0]     a;
      logic [31:0]     b;
      logic [63:0]     prod;
      a = rows[r].a;
      b = rows[r].b;
      e = '0;
      e.valid = 1'b1;
      e.tag   = 6'(r);
      case (rows[r].unit)
         U_INT: begin
            case (rows[r].op)
               issue_pkg::ALU_ADD: e.data = a + b;
               issue_pkg::ALU_SUB: e.data = a - b;
               issue_pkg::ALU_AND: e.data = a & b;
               issue_pkg::ALU_OR:  e.data = a | b;
               issue_pkg::ALU_XOR: e.data = a ^ b;
               issue_pkg::ALU_SLT: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: begin
                  e.branch = 1'b1;
                  e.taken  = (rows[r].op == issue_pkg::ALU_BEQ) ? (a == b) : (a != b);
               end
            endcase
         end
         U_LS: begin
            if (rows[r].write) begin
               ref_mem[a[LS_AW+1:2]] = b;
            end else begin
               e.data = ref_mem[a[LS_AW+1:2]];
            end
         end
         U_MUL: begin
            prod   = 64'(a) * 64'(b);
            e.data = prod[31:0];
         end
         default: e.data = (b == 32'd0) ? 32'hffff_ffff : a / b;
      endcase
      exp_res[r] = e;
   endtask

   task automatic check_cdb(input issue_pkg::cdb_t got, input issue_pkg::cdb_t exp);
      if (got.data !== exp.data) begin
         $display("[ERROR] cdb.data (tag %0h): got %h expected %h", got.tag, got.data, exp.data);
         err_count++;
      end
      if (got.branch !== exp.branch) begin
         $display("[ERROR] cdb.branch (tag %0h): got %h expected %h",
                  got.tag, got.branch, exp.branch);
         err_count++;
      end
      if (got.taken !== exp.taken) begin
         $display("[ERROR] cdb.taken (tag %0h): got %h expected %h", got.tag, got.taken, exp.taken);
         err_count++;
      end
   endtask

   task automatic check_ready(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s (cycle %0d): got %h expected %h", name, cyc, got, exp);
         err_count++;
      end
   endtask

   task automatic check_latency(input int tag, input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] latency (tag %0h): got %h expected %h", tag, got, exp);
         err_count++;
      end
   endtask

   task automatic set_inputs(input int r, input logic v);
      case (rows[r].unit)
         U_INT: begin
            int_req   = '{op: rows[r].op, rs: rows[r].a, rt: rows[r].b, rd_tag: 6'(r)};
            int_valid = v;
         end
         U_LS: begin
            ls_req   = '{write: rows[r].write, addr: rows[r].a, data: rows[r].b, tag: 6'(r)};
            ls_valid = v;
         end
         U_MUL: begin
            mul_req   = '{rs: rows[r].a, rt: rows[r].b, rd_tag: 6'(r)};
            mul_valid = v;
         end
         default: begin
            div_req   = '{rs: rows[r].a, rt: rows[r].b, rd_tag: 6'(r)};
            div_valid = v;
         end
      endcase
   endtask

   function automatic logic unit_ready(input int u);
      case (u)
         U_INT:   return int_ready;
         U_LS:    return ls_ready;
         U_MUL:   return 1'b1;
         default: return div_ready;
      endcase
   endfunction

   function automatic string unit_name(input int u);
      case (u)
         U_INT:   return "int";
         U_LS:    return "ls";
         U_MUL:   return "mul";
         default: return "div";
      endcase
   endfunction

   // one issue stream per unit, rows of that unit in table order
   task automatic drive_unit(input int u);
      int r;
      for (r = 0; r < n_rows; r++) begin
         if (rows[r].unit == u) begin
            set_inputs(r, 1'b1);
            @(negedge clk);
            while (!unit_ready(u)) @(negedge clk);
            @(posedge clk);
            #1;
            issue_cyc[r] = cyc;
            pending[r]   = 1'b1;
            n_open++;
            if (u == U_MUL) begin
               prev_mul = last_mul;
               last_mul = cyc;
            end
            if (u == U_DIV) begin
               div_busy  = 1'b1;
               div_issue = cyc;
            end
            set_inputs(r, 1'b0);
            if (rows[r].gap > 0) begin
               repeat (rows[r].gap) @(posedge clk);
               #1;
            end
         end
      end
   endtask

   always @(negedge clk) begin : monitor
      int   t;
      int   e0;
      int   lat;
      logic slot_free;
      if (checking) begin
         // bus slot is taken by a multiply due next cycle or a held divide
         slot_free = (last_mul != cyc - 1) && (prev_mul != cyc - 1)
                     && !(div_busy && (cyc >= div_issue + 32));
         check_ready("int_ready", int_ready, slot_free && (!ls_valid || prio_exp));
         check_ready("ls_ready", ls_ready, slot_free && (!int_valid || !prio_exp));
         check_ready("div_ready", div_ready, !div_busy);
         if (slot_free && int_valid && ls_valid) prio_exp = !prio_exp;
         if (cdb.valid) begin
            t = int'(cdb.tag);
            if (t >= n_rows || !pending[t]) begin
               err_count++;
               $display("tag %0d appeared on the cdb with no request outstanding", t);
            end else begin
               e0  = err_count;
               lat = cyc - issue_cyc[t] + 1;
               check_cdb(cdb, exp_res[t]);
               if (rows[t].unit == U_DIV) begin
                  if (lat < 33) begin
                     err_count++;
                     $display("divide tag %0d finished after only %0d cycles", t, lat);
                  end
                  div_busy = 1'b0;
               end else begin
                  check_latency(t, lat, (rows[t].unit == U_MUL) ? 3 : 1);
               end
               pending[t] = 1'b0;
               n_open--;
               tests_run++;
               if (err_count != e0) tests_failed++;
               $display("test %0d %s latency %0d: %s", t, unit_name(rows[t].unit), lat,
                        (err_count == e0) ? "ok" : "FAILED");
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      wait (table_done);
      limit = n_rows * 40 + 2000;
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
   end

   initial begin : main
      int r;
      int guard;
      rst_n     = 1'b0;
      int_req   = '0;
      int_valid = 1'b0;
      ls_req    = '0;
      ls_valid  = 1'b0;
      mul_req   = '0;
      mul_valid = 1'b0;
      div_req   = '0;
      div_valid = 1'b0;

      // unit, op, write, a or address, b or store data, random a/b, gap
      add_row(U_INT, issue_pkg::ALU_ADD, 1'b0, 32'd5, 32'd7, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_SUB, 1'b0, 32'd3, 32'd10, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_AND, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_INT, issue_pkg::ALU_OR,  1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_INT, issue_pkg::ALU_XOR, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_INT, issue_pkg::ALU_SLT, 1'b0, 32'hffff_fffb, 32'd3, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_SLT, 1'b0, 32'd3, 32'hffff_fffb, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_SLT, 1'b0, 32'h7fff_ffff, 32'h8000_0000, 2'b00, 1);
      add_row(U_INT, issue_pkg::ALU_BEQ, 1'b0, 32'h1234, 32'h1234, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_BEQ, 1'b0, 32'h1234, 32'h1235, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_BNE, 1'b0, 32'd1, 32'd2, 2'b00, 0);
      add_row(U_INT, issue_pkg::ALU_BNE, 1'b0, 32'd55, 32'd55, 2'b00, 2);
      add_row(U_INT, issue_pkg::ALU_ADD, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b1, 32'h04, 32'hdead_beef, 2'b00, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b1, 32'h08, 32'd0, 2'b01, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b0, 32'h04, 32'd0, 2'b00, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b0, 32'h08, 32'd0, 2'b00, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b1, 32'h04, 32'h1234_5678, 2'b00, 1);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b0, 32'h04, 32'd0, 2'b00, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b1, 32'h3c, 32'd0, 2'b01, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b0, 32'h3c, 32'd0, 2'b00, 0);
      // address above the memory wraps onto word 1
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b0, 32'h44, 32'd0, 2'b00, 0);
      add_row(U_LS,  issue_pkg::ALU_ADD, 1'b0, 32'h08, 32'd0, 2'b00, 0);
      add_row(U_MUL, issue_pkg::ALU_ADD, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_MUL, issue_pkg::ALU_ADD, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_MUL, issue_pkg::ALU_ADD, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_MUL, issue_pkg::ALU_ADD, 1'b0, 32'hffff_ffff, 32'hffff_ffff, 2'b00, 0);
      // long gap so the last multiply lands as the first divide result is held
      add_row(U_MUL, issue_pkg::ALU_ADD, 1'b0, 32'h0001_0000, 32'h0001_0000, 2'b00, 25);
      add_row(U_MUL, issue_pkg::ALU_ADD, 1'b0, 32'd12345, 32'd678, 2'b00, 0);
      add_row(U_DIV, issue_pkg::ALU_ADD, 1'b0, 32'd100, 32'd7, 2'b00, 0);
      add_row(U_DIV, issue_pkg::ALU_ADD, 1'b0, 32'd5, 32'd0, 2'b00, 0);
      add_row(U_DIV, issue_pkg::ALU_ADD, 1'b0, 32'd3, 32'd10, 2'b00, 0);
      add_row(U_DIV, issue_pkg::ALU_ADD, 1'b0, 32'd0, 32'd0, 2'b11, 0);
      add_row(U_DIV, issue_pkg::ALU_ADD, 1'b0, 32'hffff_ffff, 32'd1, 2'b00, 0);

      for (r = 0; r < n_rows; r++) begin
         if (rows[r].rnd[1]) rows[r].a = $random(seed);
         if (rows[r].rnd[0]) rows[r].b = $random(seed);
         compute_expected(r);
      end
      table_done = 1'b1;

      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      guard = err_count;
      check_ready("cdb.valid", cdb.valid, 1'b0);
      check_ready("div_ready", div_ready, 1'b1);
      check_ready("int_ready", int_ready, 1'b1);
      check_ready("ls_ready", ls_ready, 1'b1);
      tests_run++;
      if (err_count != guard) tests_failed++;
      $display("test reset state: %s", (err_count == guard) ? "ok" : "FAILED");

      @(posedge clk);
      #1;
      checking = 1'b1;
      fork
         drive_unit(U_INT);
         drive_unit(U_LS);
         drive_unit(U_MUL);
         drive_unit(U_DIV);
      join

      guard = 0;
      while (n_open > 0 && guard < 100) begin
         @(posedge clk);
         guard++;
      end
      for (r = 0; r < n_rows; r++) begin
         if (pending[r]) begin
            err_count++;
            tests_run++;
            tests_failed++;
            $display("test %0d: tag never came back on the cdb", r);
         end
      end
      $display("tests %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_top #(
   parameter int LS_DEPTH = 16
) (
   input  wire                  clk,
   input  wire                  rst_n,

   input  issue_pkg::int_req_t  int_req,
   input  wire                  int_valid,
   output logic                 int_ready,

   input  issue_pkg::ls_req_t   ls_req,
   input  wire                  ls_valid,
   output logic                 ls_ready,

   input  issue_pkg::md_req_t   mul_req,
   input  wire                  mul_valid,

   input  issue_pkg::md_req_t   div_req,
   input  wire                  div_valid,
   output logic                 div_ready,

   output issue_pkg::cdb_t      cdb
);

   issue_pkg::unit_res_t int_res;
   issue_pkg::unit_res_t ls_res;
   issue_pkg::unit_res_t mul_res;
   issue_pkg::unit_res_t div_res;
   logic                 mul_next_valid;
   logic                 div_ack;

   int_alu u_int_alu (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (int_req),
      .fire  (int_valid && int_ready),
      .res   (int_res)
   );

   ls_unit #(
      .LS_DEPTH (LS_DEPTH)
   ) u_ls_unit (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (ls_req),
      .fire  (ls_valid && ls_ready),
      .res   (ls_res)
   );

   mult_pipe u_mult_pipe (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (mul_req),
      .valid          (mul_valid),
      .res            (mul_res),
      .mul_next_valid (mul_next_valid)
   );

   div_ctrl u_div (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (div_req),
      .valid   (div_valid),
      .ready   (div_ready),
      .div_ack (div_ack),
      .res     (div_res)
   );

   cdb_scheduler u_sched (
      .clk            (clk),
      .rst_n          (rst_n),
      .int_valid      (int_valid),
      .ls_valid       (ls_valid),
      .int_ready      (int_ready),
      .ls_ready       (ls_ready),
      .mul_next_valid (mul_next_valid),
      .int_res        (int_res),
      .ls_res         (ls_res),
      .mul_res        (mul_res),
      .div_res        (div_res),
      .div_ack        (div_ack),
      .cdb            (cdb)
   );

endmodule

`default_nettype wire

// ==== hw/cdb_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_scheduler (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  int_valid,
   input  wire                  ls_valid,
   output logic                 int_ready,
   output logic                 ls_ready,
   input  wire                  mul_next_valid,
   input  issue_pkg::unit_res_t int_res,
   input  issue_pkg::unit_res_t ls_res,
   input  issue_pkg::unit_res_t mul_res,
   input  issue_pkg::unit_res_t div_res,
   output logic                 div_ack,
   output issue_pkg::cdb_t      cdb
);

   logic prio_int_q;
   logic slot_free;
   logic contend;

   // next cycle's bus slot is open for a one-cycle unit
   assign slot_free = !mul_next_valid && !div_res.valid;
   assign contend   = slot_free && int_valid && ls_valid;

   assign int_ready = slot_free && (!ls_valid || prio_int_q);
   assign ls_ready  = slot_free && (!int_valid || !prio_int_q);

   // flips only when both sides actually competed
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         prio_int_q <= 1'b1;
      end else if (contend) begin
         prio_int_q <= !prio_int_q;
      end
   end

   assign div_ack = div_res.valid && !mul_res.valid && !int_res.valid && !ls_res.valid;

   always_comb begin
      cdb = '0;
      if (mul_res.valid) begin
         cdb = issue_pkg::cdb_t'(mul_res);
      end else if (int_res.valid) begin
         cdb = issue_pkg::cdb_t'(int_res);
      end else if (ls_res.valid) begin
         cdb = issue_pkg::cdb_t'(ls_res);
      end else if (div_ack) begin
         cdb = issue_pkg::cdb_t'(div_res);
      end
   end

   // issue gating must keep the fixed-slot units apart on the bus
   assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({int_res.valid, ls_res.valid, mul_res.valid}))
      else $error("two unit results valid in one cycle");

endmodule

`default_nettype wire

// ==== divider/div_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
   input  wire                  clk,
   input  wire                  rst_n,
   input  issue_pkg::md_req_t   req,
   input  wire                  valid,
   output logic                 ready,
   input  wire                  div_ack,
   output issue_pkg::unit_res_t res
);

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,
      S_RUN  = 2'd1,
      S_HOLD = 2'd2
   } div_state_e;

   div_state_e                   state_q;
   logic                         start;
   logic                         step;
   logic                         last;
   logic [issue_pkg::DATA_W-1:0] quotient;
   logic [issue_pkg::TAG_W-1:0]  tag;

   assign ready = (state_q == S_IDLE);
   assign start = ready && valid;
   assign step  = (state_q == S_RUN);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE: if (start) state_q <= S_RUN;
            S_RUN:  if (last) state_q <= S_HOLD;
            S_HOLD: if (div_ack) state_q <= S_IDLE;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   div_step_counter u_counter (
      .clk   (clk),
      .rst_n (rst_n),
      .start (start),
      .step  (step),
      .last  (last)
   );

   div_datapath u_datapath (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .load     (start),
      .step     (step),
      .quotient (quotient),
      .tag      (tag)
   );

   assign res = '{valid: (state_q == S_HOLD), tag: tag, data: quotient,
                  branch: 1'b0, taken: 1'b0};

   // held result must not move while waiting for the bus
   assert property (@(posedge clk) disable iff (!rst_n)
      res.valid && !div_ack |=> res.valid && $stable(res.data) && $stable(res.tag))
      else $error("divider result changed before div_ack");

endmodule

`default_nettype wire

// ==== divider/div_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_datapath (
   input  wire                                clk,
   input  wire                                rst_n,
   input  issue_pkg::md_req_t                 req,
   input  wire                                load,
   input  wire                                step,
   output logic [issue_pkg::DATA_W-1:0]       quotient,
   output logic [issue_pkg::TAG_W-1:0]        tag
);

   logic [issue_pkg::DATA_W-1:0] rem_q;
   logic [issue_pkg::DATA_W-1:0] dq_q;
   logic [issue_pkg::DATA_W-1:0] dvs_q;
   logic [issue_pkg::TAG_W-1:0]  tag_q;

   logic [issue_pkg::DATA_W:0]   shifted;
   logic [issue_pkg::DATA_W:0]   diff;
   logic                         fits;

   // partial remainder with next dividend bit shifted in
   assign shifted = {rem_q, dq_q[issue_pkg::DATA_W-1]};
   assign diff    = shifted - {1'b0, dvs_q};
   // zero divisor always fits, so the quotient fills with ones
   assign fits    = (shifted >= {1'b0, dvs_q});

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rem_q <= '0;
      end else if (load) begin
         rem_q <= '0;
      end else if (step) begin
         rem_q <= fits ? diff[issue_pkg::DATA_W-1:0] : shifted[issue_pkg::DATA_W-1:0];
      end
   end

   // dividend shifts out as quotient bits shift in
   always_ff @(posedge clk) begin
      if (load) begin
         dq_q  <= req.rs;
         dvs_q <= req.rt;
         tag_q <= req.rd_tag;
      end else if (step) begin
         dq_q  <= {dq_q[issue_pkg::DATA_W-2:0], fits};
      end
   end

   assign quotient = dq_q;
   assign tag      = tag_q;

endmodule

`default_nettype wire

// ==== divider/div_step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_step_counter (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  start,
   input  wire  step,
   output logic last
);

   logic [4:0] count_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (start) begin
         count_q <= 5'd31;
      end else if (step) begin
         count_q <= count_q - 5'd1;
      end
   end

   // 32nd step
   assign last = step && (count_q == 5'd0);

endmodule

`default_nettype wire

// ==== hw/mult_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_pipe (
   input  wire                  clk,
   input  wire                  rst_n,
   input  issue_pkg::md_req_t   req,
   input  wire                  valid,
   output issue_pkg::unit_res_t res,
   output logic                 mul_next_valid
);

   logic [2:0]                   v_q;
   logic [issue_pkg::TAG_W-1:0]  tag1_q, tag2_q, tag3_q;

   // stage 1: 16x16 partial products, only low halves of the cross terms matter
   logic [31:0] ll1_q;
   logic [15:0] hl1_q, lh1_q;
   // stage 2: cross sum
   logic [31:0] ll2_q;
   logic [15:0] cross2_q;
   // stage 3: low product word
   logic [31:0] prod3_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         v_q <= '0;
      end else begin
         v_q <= {v_q[1:0], valid};
      end
   end

   always_ff @(posedge clk) begin
      ll1_q    <= req.rs[15:0] * req.rt[15:0];
      hl1_q    <= 16'(req.rs[31:16] * req.rt[15:0]);
      lh1_q    <= 16'(req.rs[15:0] * req.rt[31:16]);
      tag1_q   <= req.rd_tag;

      ll2_q    <= ll1_q;
      cross2_q <= hl1_q + lh1_q;
      tag2_q   <= tag1_q;

      prod3_q  <= ll2_q + {cross2_q, 16'd0};
      tag3_q   <= tag2_q;
   end

   assign mul_next_valid = v_q[1];
   assign res = '{valid: v_q[2], tag: tag3_q, data: prod3_q, branch: 1'b0, taken: 1'b0};

   // each accepted multiply leaves the last stage with its tag and low product
   assert property (@(posedge clk) disable iff (!rst_n)
      $past(valid, 3) |-> res.valid && res.tag == $past(req.rd_tag, 3)
                          && res.data == $past(req.rs * req.rt, 3))
      else $error("mult_pipe lost a multiply or its result");

endmodule

`default_nettype wire

// ==== hw/ls_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_unit #(
   parameter int LS_DEPTH = 16
) (
   input  wire                  clk,
   input  wire                  rst_n,
   input  issue_pkg::ls_req_t   req,
   input  wire                  fire,
   output issue_pkg::unit_res_t res
);

   localparam int AW = $clog2(LS_DEPTH);

   logic [issue_pkg::DATA_W-1:0] mem [LS_DEPTH];
   logic [AW-1:0]                idx;

   logic                         valid_q;
   logic [issue_pkg::TAG_W-1:0]  tag_q;
   logic [issue_pkg::DATA_W-1:0] rdata_q;

   // word address
   assign idx = req.addr[AW+1:2];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= fire;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         tag_q <= req.tag;
         if (req.write) begin
            mem[idx] <= req.data;
            rdata_q  <= '0;
         end else begin
            rdata_q  <= mem[idx];
         end
      end
   end

   assign res = '{valid: valid_q, tag: tag_q, data: rdata_q, branch: 1'b0, taken: 1'b0};

endmodule

`default_nettype wire

// ==== hw/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu (
   input  wire                  clk,
   input  wire                  rst_n,
   input  issue_pkg::int_req_t  req,
   input  wire                  fire,
   output issue_pkg::unit_res_t res
);

   logic [issue_pkg::DATA_W-1:0] alu_data;
   logic                         alu_branch;
   logic                         alu_taken;

   logic                         valid_q;
   logic [issue_pkg::TAG_W-1:0]  tag_q;
   logic [issue_pkg::DATA_W-1:0] data_q;
   logic                         branch_q;
   logic                         taken_q;

   always_comb begin
      alu_data   = '0;
      alu_branch = 1'b0;
      alu_taken  = 1'b0;
      case (req.op)
         issue_pkg::ALU_ADD: alu_data = req.rs + req.rt;
         issue_pkg::ALU_SUB: alu_data = req.rs - req.rt;
         issue_pkg::ALU_AND: alu_data = req.rs & req.rt;
         issue_pkg::ALU_OR:  alu_data = req.rs | req.rt;
         issue_pkg::ALU_XOR: alu_data = req.rs ^ req.rt;
         issue_pkg::ALU_SLT: alu_data = {31'd0, $signed(req.rs) < $signed(req.rt)};
         issue_pkg::ALU_BEQ: begin
            alu_branch = 1'b1;
            alu_taken  = (req.rs == req.rt);
         end
         issue_pkg::ALU_BNE: begin
            alu_branch = 1'b1;
            alu_taken  = (req.rs != req.rt);
         end
         default: alu_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= fire;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         tag_q    <= req.rd_tag;
         data_q   <= alu_data;
         branch_q <= alu_branch;
         taken_q  <= alu_taken;
      end
   end

   assign res = '{valid: valid_q, tag: tag_q, data: data_q, branch: branch_q, taken: taken_q};

endmodule

`default_nettype wire

// ==== common/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

   localparam int DATA_W = 32;
   localparam int TAG_W  = 6;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5,
      ALU_BEQ = 3'd6,
      ALU_BNE = 3'd7
   } alu_op_e;

   // integer issue word
   typedef struct packed {
      alu_op_e             op;
      logic [DATA_W-1:0]   rs;
      logic [DATA_W-1:0]   rt;
      logic [TAG_W-1:0]    rd_tag;
   } int_req_t;

   // load/store issue word, write high for a store
   typedef struct packed {
      logic                write;
      logic [DATA_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
      logic [TAG_W-1:0]    tag;
   } ls_req_t;

   // shared by multiplier and divider
   typedef struct packed {
      logic [DATA_W-1:0]   rs;
      logic [DATA_W-1:0]   rt;
      logic [TAG_W-1:0]    rd_tag;
   } md_req_t;

   typedef struct packed {
      logic                valid;
      logic [TAG_W-1:0]    tag;
      logic [DATA_W-1:0]   data;
      logic                branch;
      logic                taken;
   } unit_res_t;

   // external bus word, same layout as a unit result
   typedef struct packed {
      logic                valid;
      logic [TAG_W-1:0]    tag;
      logic [DATA_W-1:0]   data;
      logic                branch;
      logic                taken;
   } cdb_t;

endpackage

`default_nettype wire
